// File: include/dbus_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared data bus configuration
// core count, memory size, address
// regions and counter offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DBUS_CONFIG_SVH
`define DBUS_CONFIG_SVH

`define DBUS_NCORES 4
`define DMEM_ADDRW 12           // 4096 words

// address bits 30..28
`define DBUS_REGION_DMEM 3'd1   // 0x1xxxxxxx
`define DBUS_REGION_IO 3'd4     // 0x4xxxxxxx

// offsets inside the counter block, bit 2 picks the half
`define PERF_CTRL_OFS 4'h0
`define PERF_LO_OFS 4'h4
`define PERF_HI_OFS 4'h0

`endif

// File: rtl/dbus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data bus package
// region and counter command enums,
// index and width types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dbus_pkg;

`include "dbus_config.svh"

    typedef enum logic [1:0] {
        REGION_DMEM,
        REGION_PERF,
        REGION_HART,
        REGION_NONE    // unmapped, reads zero
    } region_t;

    typedef enum logic [1:0] {
        PERF_CLEAR = 2'd0,
        PERF_RUN   = 2'd1,
        PERF_HOLD  = 2'd2
    } perf_cmd_t;

    typedef logic [$clog2(`DBUS_NCORES)-1:0] core_idx_t;
    typedef logic [31:0]                     word_t;
    typedef logic [3:0]                      strb_t;
    typedef logic [`DMEM_ADDRW-1:0]          dmem_idx_t;   // word address

endpackage

// File: rtl/cycle_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64-bit cycle counter
// clear, run and hold control,
// read back in two 32-bit halves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cycle_counter (
    input  logic            clk_i,
    input  logic            rst,
    input  logic            we_i,      // control register write
    input  logic [3:0]      ofs_i,
    input  logic [1:0]      wdata_i,
    output dbus_pkg::word_t rdata_o
);
    import dbus_pkg::*;

    perf_cmd_t   cmd_q;
    logic [63:0] count_q;
    word_t       rdata_q;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            cmd_q <= PERF_CLEAR;
        end else if (we_i) begin
            cmd_q <= perf_cmd_t'(wdata_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            case (cmd_q)
                PERF_CLEAR: count_q <= '0;
                PERF_RUN:   count_q <= count_q + 64'd1;
                default:    count_q <= count_q;    // hold, code 3 too
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= ofs_i[2] ? count_q[31:0] : count_q[63:32];   // low half at +4
    end

    assign rdata_o = rdata_q;

endmodule

// File: rtl/dmem_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared data memory
// true dual port, byte lane writes,
// registered reads, cleared at start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dbus_config.svh"

module dmem_ram (
    input  logic                clk_i,
    input  logic                a_en_i,
    input  logic                a_we_i,
    input  dbus_pkg::dmem_idx_t a_addr_i,
    input  dbus_pkg::word_t     a_wdata_i,
    input  dbus_pkg::strb_t     a_wstrb_i,
    output dbus_pkg::word_t     a_rdata_o,
    input  logic                b_en_i,
    input  logic                b_we_i,
    input  dbus_pkg::dmem_idx_t b_addr_i,
    input  dbus_pkg::word_t     b_wdata_i,
    input  dbus_pkg::strb_t     b_wstrb_i,
    output dbus_pkg::word_t     b_rdata_o
);
    import dbus_pkg::*;

    localparam int DEPTH = 1 << `DMEM_ADDRW;

    word_t mem [DEPTH];

    function automatic word_t merge(word_t old, word_t wdata, strb_t wstrb);
        word_t res;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (wstrb[lane]) res[8*lane +: 8] = wdata[8*lane +: 8];
        end
        return res;
    endfunction

    initial begin
        for (int n = 0; n < DEPTH; n++) begin
            mem[n] = '0;
        end
    end

    // read returns the old word on a same-port write
    always @(posedge clk_i) begin
        if (a_en_i) begin
            a_rdata_o <= mem[a_addr_i];
            if (a_we_i) mem[a_addr_i] <= merge(mem[a_addr_i], a_wdata_i, a_wstrb_i);
        end
        if (b_en_i) begin
            b_rdata_o <= mem[b_addr_i];
            if (b_we_i) mem[b_addr_i] <= merge(mem[b_addr_i], b_wdata_i, b_wstrb_i);
        end
    end

    a_no_collide: assert property (@(posedge clk_i)
        (a_en_i && a_we_i && b_en_i && b_we_i) |-> (a_addr_i != b_addr_i));

endmodule

// File: rtl/lrsc_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load-reserved / store-conditional
// one reservation per core, broken by
// another core's write to the same word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lrsc_tracker #(
    parameter int NCORES = `DBUS_NCORES
) (
    input  logic                            clk_i,
    input  logic                            rst,
    input  logic [NCORES-1:0]               req_i,
    input  logic [NCORES-1:0]               we_i,
    input  dbus_pkg::word_t [NCORES-1:0]    addr_i,
    input  logic [NCORES-1:0]               lr_i,
    input  logic [NCORES-1:0]               sc_i,
    output logic [NCORES-1:0]               sc_ok_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0] res_vld;
    word_t             res_addr [NCORES];
    logic [NCORES-1:0] snooped;      // foreign write hits the reservation

    always_comb begin
        for (int c = 0; c < NCORES; c++) begin
            snooped[c] = 1'b0;
            for (int o = 0; o < NCORES; o++) begin
                if (o != c && req_i[o] && we_i[o]
                    && addr_i[o][31:2] == res_addr[c][31:2]) begin
                    snooped[c] = 1'b1;
                end
            end
            sc_ok_o[c] = sc_i[c] && res_vld[c] && addr_i[c][31:2] == res_addr[c][31:2];
        end
    end

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < NCORES; c++) begin
            if (rst) begin
                res_vld[c] <= 1'b0;
            end else if (lr_i[c]) begin
                res_vld[c] <= 1'b1;
            end else if (sc_i[c] || snooped[c]) begin
                res_vld[c] <= 1'b0;   // SC consumes it either way
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < NCORES; c++) begin
            if (lr_i[c]) res_addr[c] <= addr_i[c];
        end
    end

    // a consumed or broken reservation cannot pass the next SC
    for (genvar c = 0; c < NCORES; c++) begin : g_chk
        a_sc_needs_res: assert property (@(posedge clk_i) disable iff (rst)
            ((sc_i[c] || snooped[c]) && !lr_i[c]) |=> !sc_ok_o[c]);
    end

endmodule

// File: rtl/dmem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory arbiter
// one request buffer per core, two grants
// per cycle in round-robin order onto the
// RAM ports, never two on the same word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmem_arbiter #(
    parameter int NCORES = `DBUS_NCORES
) (
    input  logic                                clk_i,
    input  logic                                rst,
    input  logic [NCORES-1:0]                   req_i,
    input  logic [NCORES-1:0]                   we_i,
    input  dbus_pkg::dmem_idx_t [NCORES-1:0]    addr_i,
    input  dbus_pkg::word_t [NCORES-1:0]        wdata_i,
    input  dbus_pkg::strb_t [NCORES-1:0]        wstrb_i,
    output dbus_pkg::word_t [NCORES-1:0]        rdata_o,
    output logic [NCORES-1:0]                   busy_o,
    output logic                                a_en_o,
    output logic                                a_we_o,
    output dbus_pkg::dmem_idx_t                 a_addr_o,
    output dbus_pkg::word_t                     a_wdata_o,
    output dbus_pkg::strb_t                     a_wstrb_o,
    output logic                                b_en_o,
    output logic                                b_we_o,
    output dbus_pkg::dmem_idx_t                 b_addr_o,
    output dbus_pkg::word_t                     b_wdata_o,
    output dbus_pkg::strb_t                     b_wstrb_o,
    input  dbus_pkg::word_t                     a_rdata_i,
    input  dbus_pkg::word_t                     b_rdata_i
);
    import dbus_pkg::*;

    localparam int IW = (NCORES > 1) ? $clog2(NCORES) : 1;

    // request buffers
    logic [NCORES-1:0]      buf_vld;
    logic [NCORES-1:0]      buf_we;
    dmem_idx_t [NCORES-1:0] buf_addr;
    word_t [NCORES-1:0]     buf_wdata;
    strb_t [NCORES-1:0]     buf_wstrb;

    logic [IW-1:0]      rr_ptr;      // first core to look at
    logic               sel_a_vld, sel_b_vld;
    logic [IW-1:0]      sel_a, sel_b;
    logic [NCORES-1:0]  grant;
    logic               resp_a_vld, resp_b_vld;
    logic [IW-1:0]      resp_a, resp_b;
    word_t [NCORES-1:0] rdata_q;

    function automatic logic [IW-1:0] wrap_inc(logic [IW-1:0] idx);
        return (int'(idx) == NCORES - 1) ? '0 : idx + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < NCORES; c++) begin
            if (rst) begin
                buf_vld[c] <= 1'b0;
            end else if (req_i[c]) begin
                buf_vld[c] <= 1'b1;
            end else if (grant[c]) begin
                buf_vld[c] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < NCORES; c++) begin
            if (req_i[c]) begin
                buf_we[c]    <= we_i[c];
                buf_addr[c]  <= addr_i[c];
                buf_wdata[c] <= wdata_i[c];
                buf_wstrb[c] <= wstrb_i[c];
            end
        end
    end

    always_comb begin
        logic [IW-1:0] idx;
        idx       = '0;
        sel_a_vld = 1'b0;
        sel_b_vld = 1'b0;
        sel_a     = '0;
        sel_b     = '0;
        for (int k = 0; k < NCORES; k++) begin
            idx = IW'((int'(rr_ptr) + k) % NCORES);
            if (!sel_a_vld && buf_vld[idx]) begin
                sel_a_vld = 1'b1;
                sel_a     = idx;
            end
        end
        // port B skips anything on port A's word
        for (int k = 0; k < NCORES; k++) begin
            idx = IW'((int'(rr_ptr) + k) % NCORES);
            if (sel_a_vld && !sel_b_vld && buf_vld[idx] && idx != sel_a
                && buf_addr[idx] != buf_addr[sel_a]) begin
                sel_b_vld = 1'b1;
                sel_b     = idx;
            end
        end
    end

    for (genvar i = 0; i < NCORES; i++) begin : g_grant
        assign grant[i] = (sel_a_vld && sel_a == IW'(i)) || (sel_b_vld && sel_b == IW'(i));
        assign busy_o[i] = buf_vld[i]
                           || (resp_a_vld && resp_a == IW'(i))
                           || (resp_b_vld && resp_b == IW'(i));
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            rr_ptr     <= '0;
            resp_a_vld <= 1'b0;
            resp_b_vld <= 1'b0;
        end else begin
            resp_a_vld <= sel_a_vld;
            resp_b_vld <= sel_b_vld;
            if (sel_b_vld) begin
                rr_ptr <= wrap_inc(sel_b);
            end else if (sel_a_vld) begin
                rr_ptr <= wrap_inc(sel_a);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        resp_a <= sel_a;
        resp_b <= sel_b;
    end

    // RAM data lands one cycle after grant, kept until the next response
    always_ff @(posedge clk_i) begin
        for (int c = 0; c < NCORES; c++) begin
            if (resp_a_vld && resp_a == IW'(c)) begin
                rdata_q[c] <= a_rdata_i;
            end else if (resp_b_vld && resp_b == IW'(c)) begin
                rdata_q[c] <= b_rdata_i;
            end
        end
    end

    assign rdata_o = rdata_q;

    assign a_en_o    = sel_a_vld;
    assign a_we_o    = sel_a_vld && buf_we[sel_a];
    assign a_addr_o  = buf_addr[sel_a];
    assign a_wdata_o = buf_wdata[sel_a];
    assign a_wstrb_o = buf_wstrb[sel_a];

    assign b_en_o    = sel_b_vld;
    assign b_we_o    = sel_b_vld && buf_we[sel_b];
    assign b_addr_o  = buf_addr[sel_b];
    assign b_wdata_o = buf_wdata[sel_b];
    assign b_wstrb_o = buf_wstrb[sel_b];

    // two enabled ports consume two different buffers
    a_one_port: assert property (@(posedge clk_i) disable iff (rst)
        (a_en_o && b_en_o) |-> $countones(grant) == 2);

endmodule

// File: rtl/dbus_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-core address decoder
// routes data memory requests to the arbiter,
// owns the core's cycle counter and muxes
// the read return by the registered region
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dbus_config.svh"

module dbus_decode (
    input  logic                clk_i,
    input  logic                rst,
    input  dbus_pkg::core_idx_t core_id_i,
    input  logic                req_i,
    input  logic                we_i,
    input  dbus_pkg::word_t     addr_i,
    input  dbus_pkg::word_t     wdata_i,
    input  dbus_pkg::strb_t     wstrb_i,
    input  dbus_pkg::word_t     dm_rdata_i,
    input  logic                dm_busy_i,
    output logic                dm_req_o,
    output logic                dm_we_o,
    output dbus_pkg::dmem_idx_t dm_addr_o,
    output dbus_pkg::word_t     dm_wdata_o,
    output dbus_pkg::strb_t     dm_wstrb_o,
    output dbus_pkg::word_t     rdata_o,
    output logic                stall_o
);
    import dbus_pkg::*;

    region_t region;
    region_t region_q;     // region of the last request
    logic    perf_we;
    word_t   perf_rdata;

    always_comb begin
        if (addr_i[30:28] == `DBUS_REGION_DMEM) begin
            region = REGION_DMEM;
        end else if (addr_i[30:28] == `DBUS_REGION_IO) begin
            region = addr_i[12] ? REGION_HART : REGION_PERF;   // 0x40001xxx is hart
        end else begin
            region = REGION_NONE;   // video space lands here too
        end
    end

    assign dm_req_o   = req_i && (region == REGION_DMEM);
    assign dm_we_o    = we_i;
    assign dm_addr_o  = addr_i[`DMEM_ADDRW+1:2];
    assign dm_wdata_o = wdata_i;
    assign dm_wstrb_o = wstrb_i;

    assign perf_we = req_i && we_i && (region == REGION_PERF)
                     && (addr_i[3:0] == `PERF_CTRL_OFS);

    cycle_counter u_counter (
        .clk_i  (clk_i),
        .rst    (rst),
        .we_i   (perf_we),
        .ofs_i  (addr_i[3:0]),
        .wdata_i(wdata_i[1:0]),
        .rdata_o(perf_rdata)
    );

    // held until the next request so data memory words stay visible
    always_ff @(posedge clk_i) begin
        if (rst) begin
            region_q <= REGION_NONE;
        end else if (req_i) begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_DMEM: rdata_o = dm_rdata_i;
            REGION_PERF: rdata_o = perf_rdata;
            REGION_HART: rdata_o = word_t'(core_id_i);
            default:     rdata_o = '0;
        endcase
    end

    assign stall_o = dm_busy_i;   // only data memory ever stalls

endmodule

// File: rtl/dbus_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared data bus top level
// per-core decoders, dual-grant arbiter,
// dual-port data RAM and LR/SC tracker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dbus_top (
    input  logic                                   clk_i,
    input  logic                                   rst,
    input  logic [`DBUS_NCORES-1:0]                req_i,
    input  logic [`DBUS_NCORES-1:0]                we_i,
    input  dbus_pkg::word_t [`DBUS_NCORES-1:0]     addr_i,
    input  dbus_pkg::word_t [`DBUS_NCORES-1:0]     wdata_i,
    input  dbus_pkg::strb_t [`DBUS_NCORES-1:0]     wstrb_i,
    input  logic [`DBUS_NCORES-1:0]                lr_i,
    input  logic [`DBUS_NCORES-1:0]                sc_i,
    output dbus_pkg::word_t [`DBUS_NCORES-1:0]     rdata_o,
    output logic [`DBUS_NCORES-1:0]                stall_o,
    output logic [`DBUS_NCORES-1:0]                sc_ok_o
);
    import dbus_pkg::*;

    localparam int NC = `DBUS_NCORES;

    logic [NC-1:0]      dm_req;
    logic [NC-1:0]      dm_we;
    dmem_idx_t [NC-1:0] dm_addr;
    word_t [NC-1:0]     dm_wdata;
    strb_t [NC-1:0]     dm_wstrb;
    word_t [NC-1:0]     dm_rdata;
    logic [NC-1:0]      dm_busy;

    logic      a_en, a_we, b_en, b_we;
    dmem_idx_t a_addr, b_addr;
    word_t     a_wdata, b_wdata, a_rdata, b_rdata;
    strb_t     a_wstrb, b_wstrb;

    for (genvar i = 0; i < NC; i++) begin : g_core
        dbus_decode u_decode (
            .clk_i     (clk_i),
            .rst       (rst),
            .core_id_i (core_idx_t'(i)),
            .req_i     (req_i[i]),
            .we_i      (we_i[i]),
            .addr_i    (addr_i[i]),
            .wdata_i   (wdata_i[i]),
            .wstrb_i   (wstrb_i[i]),
            .dm_rdata_i(dm_rdata[i]),
            .dm_busy_i (dm_busy[i]),
            .dm_req_o  (dm_req[i]),
            .dm_we_o   (dm_we[i]),
            .dm_addr_o (dm_addr[i]),
            .dm_wdata_o(dm_wdata[i]),
            .dm_wstrb_o(dm_wstrb[i]),
            .rdata_o   (rdata_o[i]),
            .stall_o   (stall_o[i])
        );
    end

    dmem_arbiter #(.NCORES(NC)) u_arbiter (
        .clk_i    (clk_i),
        .rst      (rst),
        .req_i    (dm_req),
        .we_i     (dm_we),
        .addr_i   (dm_addr),
        .wdata_i  (dm_wdata),
        .wstrb_i  (dm_wstrb),
        .rdata_o  (dm_rdata),
        .busy_o   (dm_busy),
        .a_en_o   (a_en),
        .a_we_o   (a_we),
        .a_addr_o (a_addr),
        .a_wdata_o(a_wdata),
        .a_wstrb_o(a_wstrb),
        .b_en_o   (b_en),
        .b_we_o   (b_we),
        .b_addr_o (b_addr),
        .b_wdata_o(b_wdata),
        .b_wstrb_o(b_wstrb),
        .a_rdata_i(a_rdata),
        .b_rdata_i(b_rdata)
    );

    dmem_ram u_ram (
        .clk_i    (clk_i),
        .a_en_i   (a_en),
        .a_we_i   (a_we),
        .a_addr_i (a_addr),
        .a_wdata_i(a_wdata),
        .a_wstrb_i(a_wstrb),
        .a_rdata_o(a_rdata),
        .b_en_i   (b_en),
        .b_we_i   (b_we),
        .b_addr_i (b_addr),
        .b_wdata_i(b_wdata),
        .b_wstrb_i(b_wstrb),
        .b_rdata_o(b_rdata)
    );

    // snoops the raw core buses, not the arbitrated ones
    lrsc_tracker #(.NCORES(NC)) u_lrsc (
        .clk_i  (clk_i),
        .rst    (rst),
        .req_i  (req_i),
        .we_i   (we_i),
        .addr_i (addr_i),
        .lr_i   (lr_i),
        .sc_i   (sc_i),
        .sc_ok_o(sc_ok_o)
    );

endmodule

// File: bench/dbus_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data bus checker
// watches the core ports of the DUT, keeps a
// word model of data memory with byte strobes,
// judges read data and store-conditional results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dbus_config.svh"

module dbus_checker (
    input  logic                                clk_i,
    input  logic                                rst,
    input  logic [`DBUS_NCORES-1:0]             req_i,
    input  logic [`DBUS_NCORES-1:0]             we_i,
    input  dbus_pkg::word_t [`DBUS_NCORES-1:0]  addr_i,
    input  dbus_pkg::word_t [`DBUS_NCORES-1:0]  wdata_i,
    input  dbus_pkg::strb_t [`DBUS_NCORES-1:0]  wstrb_i,
    input  logic [`DBUS_NCORES-1:0]             sc_i,
    input  logic [`DBUS_NCORES-1:0]             sc_ok_i,
    input  dbus_pkg::word_t [`DBUS_NCORES-1:0]  rdata_i,
    input  logic [`DBUS_NCORES-1:0]             stall_i,
    input  logic [`DBUS_NCORES-1:0][1:0]        mode_i,    // how a read is judged
    input  dbus_pkg::word_t [`DBUS_NCORES-1:0]  exp_i,
    input  logic [`DBUS_NCORES-1:0][7:0]        id_i,      // table row of the request
    input  logic                                done_i,
    output int                                  fail_cnt_o
);
    import dbus_pkg::*;

    localparam int NC = `DBUS_NCORES;
    localparam logic [1:0] M_MODEL = 2'd0;   // memory model word
    localparam logic [1:0] M_INC   = 2'd2;   // above the last counter read
    localparam logic [1:0] M_SAME  = 2'd3;

    word_t         model [int];     // untouched words read as zero
    logic [NC-1:0] pend;
    logic [NC-1:0] pend_dmem;
    logic [NC-1:0] pend_perf;
    logic [1:0]    pend_mode [NC];
    word_t         pend_exp [NC];
    int            pend_id [NC];
    word_t         last_perf [NC];
    int            pass_cnt = 0;
    int            fail_cnt = 0;

    assign fail_cnt_o = fail_cnt;

    function automatic logic is_dmem(word_t a);
        return a[30:28] == `DBUS_REGION_DMEM;
    endfunction

    function automatic logic is_perf(word_t a);
        return (a[30:28] == `DBUS_REGION_IO) && !a[12];
    endfunction

    function automatic int word_key(word_t a);
        return int'(a[`DMEM_ADDRW+1:2]);
    endfunction

    function automatic word_t model_word(int k);
        return model.exists(k) ? model[k] : '0;
    endfunction

    task automatic store_word(word_t a, word_t d, strb_t s);
        word_t w;
        w = model_word(word_key(a));
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        model[word_key(a)] = w;
    endtask

    task automatic report(int id, int c, logic ok, string sig, word_t got,
                          string rel, word_t expv);
        if (ok) begin
            pass_cnt++;
            $display("test %0d core %0d ok", id, c);
        end else begin
            fail_cnt++;
            $display("error: test %0d %s[%0d] got %h expected %s%h", id, sig, c, got, rel, expv);
        end
    endtask

    task automatic take_request(int c);
        if (we_i[c]) begin
            if (is_dmem(addr_i[c])) begin
                store_word(addr_i[c], wdata_i[c], wstrb_i[c]);
            end
        end else begin
            pend[c]      = 1'b1;
            pend_dmem[c] = is_dmem(addr_i[c]);
            pend_perf[c] = is_perf(addr_i[c]);
            pend_mode[c] = mode_i[c];
            pend_id[c]   = int'(id_i[c]);
            pend_exp[c]  = (mode_i[c] == M_MODEL) ? model_word(word_key(addr_i[c])) : exp_i[c];
        end
    endtask

    task automatic check_response(int c);
        word_t got;
        word_t expv;
        logic  ok;
        string rel;
        got = rdata_i[c];
        rel = "";
        expv = pend_exp[c];
        case (pend_mode[c])
            M_INC: begin
                expv = last_perf[c];
                rel  = "above ";
                ok   = got > expv;
            end
            M_SAME: begin
                expv = last_perf[c];
                ok   = got == expv;
            end
            default: ok = got == expv;
        endcase
        if (pend_perf[c]) begin
            last_perf[c] = got;
        end
        report(pend_id[c], c, ok, "rdata_o", got, rel, expv);
    endtask

    always @(posedge clk_i) begin
        if (rst) begin
            pend = '0;
            for (int c = 0; c < NC; c++) begin
                last_perf[c] = '0;
            end
        end else begin
            for (int c = 0; c < NC; c++) begin
                if (pend[c] && !stall_i[c]) begin
                    pend[c] = 1'b0;
                    check_response(c);
                end else if (pend[c] && !pend_dmem[c]) begin
                    pend[c] = 1'b0;   // only data memory may stall
                    fail_cnt++;
                    $display("test %0d: core %0d stalled on a read outside data memory",
                             pend_id[c], c);
                end
                if (req_i[c] && sc_i[c]) begin
                    report(int'(id_i[c]), c, sc_ok_i[c] == exp_i[c][0], "sc_ok_o",
                           word_t'(sc_ok_i[c]), "", word_t'(exp_i[c][0]));
                end
                if (req_i[c]) begin
                    take_request(c);
                end
            end
        end
    end

    always @(posedge done_i) begin
        $display("checks: %0d run, %0d passed, %0d failed",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    end

endmodule

// File: bench/tb_dbus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared data bus testbench
// clock and reset, a table of bus operations
// applied in order, groups issued in one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dbus_config.svh"

module tb_dbus;
    import dbus_pkg::*;

    localparam int NC      = `DBUS_NCORES;
    localparam int TIMEOUT = 200;   // cycles per wait

    localparam logic [1:0] M_MODEL = 2'd0;
    localparam logic [1:0] M_VALUE = 2'd1;
    localparam logic [1:0] M_INC   = 2'd2;
    localparam logic [1:0] M_SAME  = 2'd3;

    localparam word_t PERF_CTRL = 32'h4000_0000 + `PERF_CTRL_OFS;
    localparam word_t PERF_LO   = 32'h4000_0000 + `PERF_LO_OFS;
    localparam word_t HART_IDX  = 32'h4000_1000;

    typedef enum logic [2:0] {K_READ, K_WRITE, K_LR, K_SC, K_IDLE} kind_t;

    typedef struct packed {
        logic [7:0] core;
        kind_t      kind;
        word_t      addr;
        word_t      data;    // cycle count for idle rows
        strb_t      strb;
        logic [1:0] mode;
        word_t      expv;    // sc rows use bit 0
        logic       last;    // closes a group issued in one cycle
    } row_t;

    logic               clk_i;
    logic               rst;
    logic [NC-1:0]      req, we, lr, sc;
    logic [NC-1:0]      stall, sc_ok;
    word_t [NC-1:0]     addr, wdata, rdata;
    strb_t [NC-1:0]     wstrb;
    logic [NC-1:0][1:0] chk_mode;
    word_t [NC-1:0]     chk_exp;
    logic [NC-1:0][7:0] chk_id;
    logic               done;
    int                 chk_fails;
    logic               timed_out;
    int                 seed;
    row_t               rows[$];

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    dbus_top dut_i (
        .clk_i  (clk_i),
        .rst    (rst),
        .req_i  (req),
        .we_i   (we),
        .addr_i (addr),
        .wdata_i(wdata),
        .wstrb_i(wstrb),
        .lr_i   (lr),
        .sc_i   (sc),
        .rdata_o(rdata),
        .stall_o(stall),
        .sc_ok_o(sc_ok)
    );

    dbus_checker u_check (
        .clk_i     (clk_i),
        .rst       (rst),
        .req_i     (req),
        .we_i      (we),
        .addr_i    (addr),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .sc_i      (sc),
        .sc_ok_i   (sc_ok),
        .rdata_i   (rdata),
        .stall_i   (stall),
        .mode_i    (chk_mode),
        .exp_i     (chk_exp),
        .id_i      (chk_id),
        .done_i    (done),
        .fail_cnt_o(chk_fails)
    );

    function automatic word_t rnd_word();
        return word_t'($random(seed));
    endfunction

    task automatic add_row(int core, kind_t kind, word_t a, word_t d, strb_t s,
                           logic [1:0] mode, word_t expv, logic last);
        row_t r;
        r.core = 8'(core);
        r.kind = kind;
        r.addr = a;
        r.data = d;
        r.strb = s;
        r.mode = mode;
        r.expv = expv;
        r.last = last;
        rows.push_back(r);
    endtask

    task automatic add_idle(int n);
        add_row(0, K_IDLE, '0, word_t'(n), 4'h0, M_MODEL, '0, 1'b1);
    endtask

    task automatic build_table();
        // write and read back one word, then partial strobes
        add_row(0, K_WRITE, 32'h1000_0100, rnd_word(), 4'hf, M_MODEL, '0, 1'b1);
        add_row(0, K_READ, 32'h1000_0100, '0, 4'h0, M_MODEL, '0, 1'b1);
        add_row(0, K_WRITE, 32'h1000_0100, rnd_word(), 4'b0101, M_MODEL, '0, 1'b1);
        add_row(0, K_READ, 32'h1000_0100, '0, 4'h0, M_MODEL, '0, 1'b1);
        add_row(0, K_WRITE, 32'h1000_0100, rnd_word(), 4'b1000, M_MODEL, '0, 1'b1);
        add_row(0, K_READ, 32'h1000_0100, '0, 4'h0, M_MODEL, '0, 1'b1);
        // every core writes in the same cycle, then all read back
        for (int c = 0; c < NC; c++) begin
            add_row(c, K_WRITE, 32'h1000_0200 + 32'(4 * c), rnd_word(), 4'hf, M_MODEL, '0,
                    c == NC - 1);
        end
        for (int c = 0; c < NC; c++) begin
            add_row(c, K_READ, 32'h1000_0200 + 32'(4 * c), '0, 4'h0, M_MODEL, '0, c == NC - 1);
        end
        // hart index, no stall
        for (int c = 0; c < NC; c++) begin
            add_row(c, K_READ, HART_IDX, '0, 4'h0, M_VALUE, word_t'(c), c == NC - 1);
        end
        // cycle counter on core 1
        add_row(1, K_WRITE, PERF_CTRL, word_t'(PERF_CLEAR), 4'hf, M_MODEL, '0, 1'b1);
        add_idle(2);
        add_row(1, K_READ, PERF_LO, '0, 4'h0, M_VALUE, '0, 1'b1);
        add_row(1, K_WRITE, PERF_CTRL, word_t'(PERF_RUN), 4'hf, M_MODEL, '0, 1'b1);
        add_idle(3);
        add_row(1, K_READ, PERF_LO, '0, 4'h0, M_INC, '0, 1'b1);
        add_idle(4);
        add_row(1, K_READ, PERF_LO, '0, 4'h0, M_INC, '0, 1'b1);
        add_row(1, K_WRITE, PERF_CTRL, word_t'(PERF_HOLD), 4'hf, M_MODEL, '0, 1'b1);
        add_idle(2);
        add_row(1, K_READ, PERF_LO, '0, 4'h0, M_INC, '0, 1'b1);
        add_idle(4);
        add_row(1, K_READ, PERF_LO, '0, 4'h0, M_SAME, '0, 1'b1);
        add_row(1, K_WRITE, PERF_CTRL, word_t'(PERF_CLEAR), 4'hf, M_MODEL, '0, 1'b1);
        add_idle(2);
        add_row(1, K_READ, PERF_LO, '0, 4'h0, M_VALUE, '0, 1'b1);
        // reservations
        add_row(2, K_LR, 32'h1000_0300, '0, 4'h0, M_MODEL, '0, 1'b1);
        add_row(2, K_SC, 32'h1000_0300, rnd_word(), 4'hf, M_MODEL, 32'd1, 1'b1);
        add_row(2, K_SC, 32'h1000_0300, rnd_word(), 4'hf, M_MODEL, 32'd0, 1'b1);
        add_row(2, K_LR, 32'h1000_0304, '0, 4'h0, M_MODEL, '0, 1'b1);
        add_row(3, K_WRITE, 32'h1000_0304, rnd_word(), 4'hf, M_MODEL, '0, 1'b1);
        add_row(2, K_SC, 32'h1000_0304, rnd_word(), 4'hf, M_MODEL, 32'd0, 1'b1);
        add_row(2, K_READ, 32'h1000_0304, '0, 4'h0, M_MODEL, '0, 1'b1);
        // unmapped space, same low bits as a data word
        add_row(3, K_WRITE, 32'h1000_0010, rnd_word(), 4'hf, M_MODEL, '0, 1'b1);
        add_row(3, K_WRITE, 32'h2000_0010, rnd_word(), 4'hf, M_MODEL, '0, 1'b1);
        add_row(3, K_READ, 32'h2000_0010, '0, 4'h0, M_VALUE, '0, 1'b1);
        add_row(3, K_READ, 32'h3000_0000, '0, 4'h0, M_VALUE, '0, 1'b1);   // video space
        add_row(3, K_READ, 32'h1000_0010, '0, 4'h0, M_MODEL, '0, 1'b1);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic drive_row(row_t r, int idx);
        int c;
        c = int'(r.core);
        req[c]      = 1'b1;
        we[c]       = (r.kind == K_WRITE) || (r.kind == K_SC);
        lr[c]       = (r.kind == K_LR);
        sc[c]       = (r.kind == K_SC);
        addr[c]     = r.addr;
        wdata[c]    = r.data;
        wstrb[c]    = r.strb;
        chk_mode[c] = r.mode;
        chk_exp[c]  = r.expv;
        chk_id[c]   = 8'(idx);
    endtask

    task automatic wait_ready(logic [NC-1:0] mask);
        int n;
        n = 0;
        while ((stall & mask) != '0 && n < TIMEOUT) begin
            @(posedge clk_i);
            #2;
            n++;
        end
        if ((stall & mask) != '0) begin
            $display("timeout: cores %b still stalled after %0d cycles", stall & mask, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_rows();
        int            i;
        logic [NC-1:0] mask;
        row_t          r;
        i = 0;
        while (i < rows.size() && !timed_out) begin
            r = rows[i];
            if (r.kind == K_IDLE) begin
                idle_cycles(int'(r.data));
                i++;
            end else begin
                mask = '0;
                do begin
                    r = rows[i];
                    drive_row(r, i);
                    mask[r.core] = 1'b1;
                    i++;
                end while (!r.last && i < rows.size());
                @(posedge clk_i);
                #2;
                req = '0;
                lr  = '0;
                sc  = '0;
                wait_ready(mask);
            end
        end
    endtask

    initial begin
        seed      = 32'ha8ea;
        timed_out = 1'b0;
        done      = 1'b0;
        rst       = 1'b1;
        req       = '0;
        we        = '0;
        lr        = '0;
        sc        = '0;
        addr      = '0;
        wdata     = '0;
        wstrb     = '0;
        chk_mode  = '0;
        chk_exp   = '0;
        chk_id    = '0;
        build_table();
        repeat (16) @(posedge clk_i);
        #2;
        rst = 1'b0;
        apply_rows();
        idle_cycles(2);   // last response reaches the checker
        done = 1'b1;
        #1;
        if (!timed_out && chk_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
rtl/dbus_pkg.sv
rtl/cycle_counter.sv
rtl/dmem_ram.sv
rtl/lrsc_tracker.sv
rtl/dmem_arbiter.sv
rtl/dbus_decode.sv
rtl/dbus_top.sv
bench/dbus_checker.sv
bench/tb_dbus.sv

// File: Makefile
# Verilator build and run of the shared data bus testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -f all.f \
		--top-module tb_dbus -Mdir obj_dir -o tb_dbus
	./obj_dir/tb_dbus | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
